/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* icache_asserts.sv */
`timescale 1ns/1ps

module icache_asserts (
    input logic clk,
    input logic rst,
    input logic o_arvalid,
    input logic i_arready,
    input logic [31:0] o_araddr,
    input logic o_rready,
    input logic i_rvalid,
    input logic o_fetch_valid
);

    // AR held with a stable address until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else $error("ARVALID dropped or ARADDR changed before ARREADY");

    // data phase opens right after the address handshake
    rready_start: assert property (@(posedge clk) disable iff (!rst)
        o_arvalid && i_arready |=> o_rready)
        else $error("RREADY not raised after the AR handshake");

    rready_hold: assert property (@(posedge clk) disable iff (!rst)
        o_rready && !i_rvalid |=> o_rready)
        else $error("RREADY dropped before the R handshake");

    // response lasts one cycle
    valid_pulse: assert property (@(posedge clk) disable iff (!rst)
        o_fetch_valid |=> !o_fetch_valid)
        else $error("fetch valid held longer than one cycle");

endmodule

bind icache_top icache_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .o_arvalid     (o_arvalid),
    .i_arready     (i_arready),
    .o_araddr      (o_araddr),
    .o_rready      (o_rready),
    .i_rvalid      (i_rvalid),
    .o_fetch_valid (o_fetch_valid)
);

/* icache_axil_refill.sv */
`timescale 1ns/1ps

module icache_axil_refill #(
    parameter int ADDR_W = 32
) (
    input  logic                     clk,
    input  logic                     rst,

    // controller side
    input  logic                     i_refill_req,
    input  logic [ADDR_W-1:0]        i_refill_addr,
    output logic                     o_refill_done,
    output icache_pkg::icache_line_t o_refill_data,
    output logic                     o_refill_err,

    // AXI4-Lite read channels
    output logic [ADDR_W-1:0]        o_araddr,
    output logic                     o_arvalid,
    output logic [2:0]               o_arprot,
    input  logic                     i_arready,
    input  logic                     i_rvalid,
    input  icache_pkg::icache_line_t i_rdata,
    input  icache_pkg::axi_resp_t    i_rresp,
    output logic                     o_rready
);

    import icache_pkg::*;

    // idle plus address, data and done phases
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ADDR,
        PH_DATA,
        PH_DONE
    } phase_e;

    phase_e phase;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE: if (i_refill_req) phase <= PH_ADDR;
                PH_ADDR: if (i_arready)    phase <= PH_DATA;
                PH_DATA: if (i_rvalid)     phase <= PH_DONE;
                default:                   phase <= PH_IDLE;
            endcase
        end
    end

    // address held stable for the whole AR phase
    always_ff @(posedge clk) begin
        if ((phase == PH_IDLE) && i_refill_req) begin
            o_araddr <= i_refill_addr;
        end
        if ((phase == PH_DATA) && i_rvalid) begin
            o_refill_data <= i_rdata;
            o_refill_err  <= (i_rresp != RESP_OKAY);
        end
    end

    assign o_arvalid     = (phase == PH_ADDR);
    assign o_rready      = (phase == PH_DATA);
    assign o_refill_done = (phase == PH_DONE);
    assign o_arprot      = ARPROT_INST;

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int  ADDR_W   = 32,
    parameter int  SET_BITS = 6,
    localparam int TAG_W    = ADDR_W - SET_BITS - icache_pkg::OFFSET_BITS
) (
    input  logic                      clk,
    input  logic                      rst,

    // fetch port
    input  logic                      i_fetch_req,
    input  logic [ADDR_W-1:0]         i_fetch_addr,
    input  logic                      i_flush,
    output logic                      o_fetch_ready,
    output logic                      o_fetch_valid,
    output icache_pkg::icache_inst_t  o_fetch_data,
    output logic                      o_fetch_err,

    // refill master
    output logic                      o_refill_req,
    output logic [ADDR_W-1:0]         o_refill_addr,
    input  logic                      i_refill_done,
    input  icache_pkg::icache_line_t  i_refill_data,
    input  logic                      i_refill_err,

    // way RAMs
    output logic [SET_BITS-1:0]       o_ram_index,
    output logic [1:0]                o_tag_we,
    output logic [TAG_W-1:0]          o_tag_wdata,
    input  logic [TAG_W-1:0]          i_tag_rdata0,
    input  logic [TAG_W-1:0]          i_tag_rdata1,
    output logic [1:0]                o_data_we,
    output icache_pkg::icache_line_t  o_data_wdata,
    input  icache_pkg::icache_line_t  i_data_rdata0,
    input  icache_pkg::icache_line_t  i_data_rdata1
);

    import icache_pkg::*;

    localparam int NSETS = 2 ** SET_BITS;

    icache_state_e state;
    icache_state_e state_nxt;

    // latched request
    logic [ADDR_W-1:0]   addr_q;
    logic [SET_BITS-1:0] idx;
    logic [TAG_W-1:0]    tag;
    logic                word_sel;

    // high in the second LOOKUP cycle, RAM outputs are valid then
    logic lookup_rd;

    // per-set state
    logic [NSETS-1:0] valid0;
    logic [NSETS-1:0] valid1;
    // points at the least recently used way
    logic [NSETS-1:0] lru;

    logic         hit0;
    logic         hit1;
    logic         hit;
    icache_line_t hit_line;
    logic         victim;
    logic         victim_q;
    logic         compare;
    logic         fill_ok;

    // upper word at address bit 2 set
    function automatic icache_inst_t pick_word(icache_line_t line, logic upper);
        icache_inst_t w;
        w = upper ? line[LINE_W-1:INST_W] : line[INST_W-1:0];
        return w;
    endfunction

    assign idx      = addr_q[OFFSET_BITS +: SET_BITS];
    assign tag      = addr_q[ADDR_W-1 -: TAG_W];
    assign word_sel = addr_q[2];

    // tag compare, each way qualified by its own valid bit
    assign hit0     = valid0[idx] && (i_tag_rdata0 == tag);
    assign hit1     = valid1[idx] && (i_tag_rdata1 == tag);
    assign hit      = hit0 || hit1;
    assign hit_line = hit0 ? i_data_rdata0 : i_data_rdata1;

    // invalid way first, else the LRU way
    assign victim = !valid0[idx] ? 1'b0 :
                    !valid1[idx] ? 1'b1 :
                    lru[idx];

    assign compare = (state == LOOKUP) && lookup_rd;
    assign fill_ok = (state == REFILL) && i_refill_done && !i_refill_err;

    assign o_fetch_ready = (state == IDLE);
    assign o_fetch_valid = (state == RESPOND);

    assign o_refill_req  = (state == REFILL);
    assign o_refill_addr = {addr_q[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign o_ram_index  = idx;
    assign o_tag_wdata  = tag;
    assign o_data_wdata = i_refill_data;
    assign o_tag_we     = fill_ok ? (victim_q ? 2'b10 : 2'b01) : 2'b00;
    assign o_data_we    = o_tag_we;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_fetch_req && !i_flush) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_rd) begin
                    state_nxt = hit ? RESPOND : REFILL;
                end
            end
            REFILL: begin
                if (i_refill_done) begin
                    state_nxt = RESPOND;
                end
            end
            RESPOND: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= IDLE;
            lookup_rd <= 1'b0;
        end else begin
            state     <= state_nxt;
            lookup_rd <= (state == LOOKUP) && !lookup_rd;
        end
    end

    // valid and LRU bits
    // a flush wins over a request in the same cycle, the request waits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid0 <= '0;
            valid1 <= '0;
            lru    <= '0;
        end else if ((state == IDLE) && i_flush) begin
            valid0 <= '0;
            valid1 <= '0;
            lru    <= '0;
        end else if (compare && hit) begin
            // other way becomes LRU
            lru[idx] <= hit0;
        end else if (fill_ok) begin
            if (victim_q) begin
                valid1[idx] <= 1'b1;
            end else begin
                valid0[idx] <= 1'b1;
            end
            lru[idx] <= ~victim_q;
        end
    end

    // request address, victim and response payload
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_fetch_req && !i_flush) begin
            addr_q <= i_fetch_addr;
        end
        if (compare) begin
            victim_q <= victim;
        end
        if (compare && hit) begin
            o_fetch_data <= pick_word(hit_line, word_sel);
            o_fetch_err  <= 1'b0;
        end else if ((state == REFILL) && i_refill_done) begin
            // on error the data still goes out, flagged
            o_fetch_data <= pick_word(i_refill_data, word_sel);
            o_fetch_err  <= i_refill_err;
        end
    end

endmodule

/* icache_pkg.sv */
package icache_pkg;

    // line and word geometry
    localparam int LINE_W      = 64;
    localparam int INST_W      = 32;
    localparam int OFFSET_BITS = 3;

    // one cache line, also the width of an AXI read beat
    typedef logic [LINE_W-1:0] icache_line_t;

    // one fetched instruction
    typedef logic [INST_W-1:0] icache_inst_t;

    // AXI response codes
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // instruction access, secure, unprivileged
    localparam logic [2:0] ARPROT_INST = 3'b100;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } icache_state_e;

endpackage

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int ADDR_W   = 32,
    parameter int SET_BITS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_fetch_req,
    input  logic [ADDR_W-1:0]        i_fetch_addr,
    input  logic                     i_flush,
    output logic                     o_fetch_ready,
    output logic                     o_fetch_valid,
    output icache_pkg::icache_inst_t o_fetch_data,
    output logic                     o_fetch_err,
    output logic [ADDR_W-1:0]        o_araddr,
    output logic                     o_arvalid,
    output logic [2:0]               o_arprot,
    input  logic                     i_arready,
    input  logic                     i_rvalid,
    input  icache_pkg::icache_line_t i_rdata,
    input  icache_pkg::axi_resp_t    i_rresp,
    output logic                     o_rready
);

    import icache_pkg::*;

    localparam int TAG_W = ADDR_W - SET_BITS - OFFSET_BITS;

    typedef logic [TAG_W-1:0] tag_t;

    // controller to refill master
    logic         refill_req;
    logic [ADDR_W-1:0] refill_addr;
    logic         refill_done;
    icache_line_t refill_data;
    logic         refill_err;

    // controller to way RAMs
    logic [SET_BITS-1:0] ram_index;
    logic [1:0]   tag_we;
    tag_t         tag_wdata;
    tag_t         tag_rdata0;
    tag_t         tag_rdata1;
    logic [1:0]   data_we;
    icache_line_t data_wdata;
    icache_line_t data_rdata0;
    icache_line_t data_rdata1;

    icache_ctrl #(
        .ADDR_W   (ADDR_W),
        .SET_BITS (SET_BITS)
    ) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .i_flush       (i_flush),
        .o_fetch_ready (o_fetch_ready),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .o_fetch_err   (o_fetch_err),
        .o_refill_req  (refill_req),
        .o_refill_addr (refill_addr),
        .i_refill_done (refill_done),
        .i_refill_data (refill_data),
        .i_refill_err  (refill_err),
        .o_ram_index   (ram_index),
        .o_tag_we      (tag_we),
        .o_tag_wdata   (tag_wdata),
        .i_tag_rdata0  (tag_rdata0),
        .i_tag_rdata1  (tag_rdata1),
        .o_data_we     (data_we),
        .o_data_wdata  (data_wdata),
        .i_data_rdata0 (data_rdata0),
        .i_data_rdata1 (data_rdata1)
    );

    icache_axil_refill #(
        .ADDR_W (ADDR_W)
    ) u_refill (
        .clk           (clk),
        .rst           (rst),
        .i_refill_req  (refill_req),
        .i_refill_addr (refill_addr),
        .o_refill_done (refill_done),
        .o_refill_data (refill_data),
        .o_refill_err  (refill_err),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .o_arprot      (o_arprot),
        .i_arready     (i_arready),
        .i_rvalid      (i_rvalid),
        .i_rdata       (i_rdata),
        .i_rresp       (i_rresp),
        .o_rready      (o_rready)
    );

    // way 0
    icache_way_ram #(.T(tag_t), .SET_BITS(SET_BITS)) u_tag_ram0 (
        .clk     (clk),
        .i_addr  (ram_index),
        .i_we    (tag_we[0]),
        .i_wdata (tag_wdata),
        .o_rdata (tag_rdata0)
    );

    icache_way_ram #(.T(icache_line_t), .SET_BITS(SET_BITS)) u_data_ram0 (
        .clk     (clk),
        .i_addr  (ram_index),
        .i_we    (data_we[0]),
        .i_wdata (data_wdata),
        .o_rdata (data_rdata0)
    );

    // way 1
    icache_way_ram #(.T(tag_t), .SET_BITS(SET_BITS)) u_tag_ram1 (
        .clk     (clk),
        .i_addr  (ram_index),
        .i_we    (tag_we[1]),
        .i_wdata (tag_wdata),
        .o_rdata (tag_rdata1)
    );

    icache_way_ram #(.T(icache_line_t), .SET_BITS(SET_BITS)) u_data_ram1 (
        .clk     (clk),
        .i_addr  (ram_index),
        .i_we    (data_we[1]),
        .i_wdata (data_wdata),
        .o_rdata (data_rdata1)
    );

endmodule

/* icache_way_ram.sv */
`timescale 1ns/1ps

module icache_way_ram #(
    parameter type T        = logic,
    parameter int  SET_BITS = 6
) (
    input  logic                clk,
    input  logic [SET_BITS-1:0] i_addr,
    input  logic                i_we,
    input  T                    i_wdata,
    output T                    o_rdata
);

    localparam int DEPTH = 2 ** SET_BITS;

    // one entry per set
    T mem [DEPTH];

    // registered read port, index sampled on the clock edge
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
            // written value shows up on the output right away
            o_rdata     <= i_wdata;
        end else begin
            o_rdata     <= mem[i_addr];
        end
    end

endmodule

/* sources.f */
icache_pkg.sv
icache_way_ram.sv
icache_ctrl.sv
icache_axil_refill.sv
icache_top.sv
tb_clkgen.sv
tb_axil_mem.sv
tb_checker.sv
icache_asserts.sv
tb_icache.sv

/* tb_axil_mem.sv */
`timescale 1ns/1ps

module tb_axil_mem #(
    parameter int          ADDR_W = 32,
    parameter logic [31:0] SEED   = 32'hfb99_35bc
) (
    input  logic                     clk,
    input  logic [ADDR_W-1:0]        i_araddr,
    input  logic                     i_arvalid,
    input  logic                     i_rready,
    output logic                     o_arready,
    output logic                     o_rvalid,
    output icache_pkg::icache_line_t o_rdata,
    output icache_pkg::axi_resp_t    o_rresp
);

    import icache_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    int                stall;

    initial begin
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rdata   = '0;
        o_rresp   = RESP_OKAY;
        // single seed for the whole run
        stall     = $urandom(SEED);
        forever begin
            @(negedge clk);
            if (i_arvalid) begin
                stall = $urandom % 4;
                repeat (stall) @(negedge clk);
                o_arready = 1'b1;
                addr_q    = i_araddr;
                @(negedge clk);
                o_arready = 1'b0;
                stall = $urandom % 4;
                repeat (stall) @(negedge clk);
                // line at A is {A, ~A}
                o_rvalid = 1'b1;
                o_rdata  = {addr_q[31:0], ~addr_q[31:0]};
                // 0x3000 to 0x30ff answers with SLVERR
                o_rresp  = (addr_q[31:8] == 24'h000030) ? RESP_SLVERR : RESP_OKAY;
                // beat held until the master takes it
                while (!i_rready) @(negedge clk);
                @(negedge clk);
                o_rvalid = 1'b0;
            end
        end
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int ADDR_W   = 32,
    parameter int SET_BITS = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_fetch_req,
    input  logic [ADDR_W-1:0]       i_fetch_addr,
    input  logic                    i_flush,
    input  logic                    i_exp_hit,
    input  logic                    i_fetch_ready,
    input  logic                    i_fetch_valid,
    input  icache_pkg::icache_inst_t i_fetch_data,
    input  logic                    i_fetch_err,
    input  logic [ADDR_W-1:0]       i_araddr,
    input  logic                    i_arvalid,
    input  logic [2:0]              i_arprot,
    input  logic                    i_arready,
    output int                      o_errors,
    output int                      o_checks,
    output int                      o_responses
);

    import icache_pkg::*;

    localparam int NSETS = 2 ** SET_BITS;
    // accepted at edge k, valid seen at edge k+3, so 2 cycles of latency
    localparam int HIT_SAMPLE_GAP = 3;

    logic [ADDR_W-1:0] tag_m0 [NSETS];
    logic [ADDR_W-1:0] tag_m1 [NSETS];
    logic              val_m0 [NSETS];
    logic              val_m1 [NSETS];
    logic              lru_m  [NSETS];

    int                edge_cnt;
    int                acc_edge;
    int                ar_cnt;
    logic              busy;
    logic [ADDR_W-1:0] cur_addr;
    logic              pred_hit;
    logic              pred_way;

    function automatic int set_of(logic [ADDR_W-1:0] a);
        return int'(a[OFFSET_BITS +: SET_BITS]);
    endfunction

    function automatic logic [ADDR_W-1:0] tag_of(logic [ADDR_W-1:0] a);
        return a >> (OFFSET_BITS + SET_BITS);
    endfunction

    function automatic logic [31:0] expect_word(logic [ADDR_W-1:0] a);
        logic [31:0] base;
        base = {a[31:3], 3'b000};
        return a[2] ? base : ~base;
    endfunction

    function automatic logic in_err_region(logic [ADDR_W-1:0] a);
        return a[31:8] == 24'h000030;
    endfunction

    task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
        o_checks = o_checks + 1;
        if (got !== exp) begin
            $display("FAILED %0t %s: got %0h expected %0h", $time, name, got, exp);
            o_errors = o_errors + 1;
        end
    endtask

    task automatic report_text(string what);
        $display("error at %0t: %s", $time, what);
        o_errors = o_errors + 1;
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NSETS; i++) begin
                val_m0[i] <= 1'b0;
                val_m1[i] <= 1'b0;
                lru_m[i]  <= 1'b0;
            end
            edge_cnt    <= 0;
            busy        <= 1'b0;
            ar_cnt      <= 0;
            o_errors    = 0;
            o_checks    = 0;
            o_responses <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
            if (busy && i_fetch_ready) begin
                report_text("fetch ready high while a request is pending");
            end
            if (i_arvalid && i_arready) begin
                ar_cnt <= ar_cnt + 1;
                if (!busy) begin
                    report_text("AR handshake with no fetch pending");
                end
                report_value("o_araddr", 64'(i_araddr), 64'({cur_addr[31:3], 3'b000}));
                report_value("o_arprot", 64'(i_arprot), 64'(ARPROT_INST));
            end
            if (i_fetch_valid) begin
                if (!busy) begin
                    report_text("fetch valid without an accepted request");
                end else begin
                    o_responses <= o_responses + 1;
                    report_value("o_fetch_data", 64'(i_fetch_data), 64'(expect_word(cur_addr)));
                    report_value("o_fetch_err", 64'(i_fetch_err),
                                 64'(!pred_hit && in_err_region(cur_addr)));
                    report_value("ar_count", 64'(ar_cnt), pred_hit ? 64'd0 : 64'd1);
                    if (pred_hit) begin
                        report_value("hit_latency", 64'(edge_cnt - acc_edge),
                                     64'(HIT_SAMPLE_GAP));
                        lru_m[set_of(cur_addr)] <= ~pred_way;
                    end else if (!in_err_region(cur_addr)) begin
                        // allocate into the predicted victim
                        if (pred_way) begin
                            tag_m1[set_of(cur_addr)] <= tag_of(cur_addr);
                            val_m1[set_of(cur_addr)] <= 1'b1;
                        end else begin
                            tag_m0[set_of(cur_addr)] <= tag_of(cur_addr);
                            val_m0[set_of(cur_addr)] <= 1'b1;
                        end
                        lru_m[set_of(cur_addr)] <= ~pred_way;
                    end
                end
                busy <= 1'b0;
            end
            if (i_fetch_ready && i_flush) begin
                for (int i = 0; i < NSETS; i++) begin
                    val_m0[i] <= 1'b0;
                    val_m1[i] <= 1'b0;
                    lru_m[i]  <= 1'b0;
                end
            end else if (i_fetch_ready && i_fetch_req) begin
                busy     <= 1'b1;
                cur_addr <= i_fetch_addr;
                acc_edge <= edge_cnt;
                ar_cnt   <= 0;
                if (val_m0[set_of(i_fetch_addr)] &&
                    tag_m0[set_of(i_fetch_addr)] == tag_of(i_fetch_addr)) begin
                    pred_hit <= 1'b1;
                    pred_way <= 1'b0;
                end else if (val_m1[set_of(i_fetch_addr)] &&
                             tag_m1[set_of(i_fetch_addr)] == tag_of(i_fetch_addr)) begin
                    pred_hit <= 1'b1;
                    pred_way <= 1'b1;
                end else begin
                    pred_hit <= 1'b0;
                    // invalid way first, else the LRU way
                    pred_way <= !val_m0[set_of(i_fetch_addr)] ? 1'b0 :
                                !val_m1[set_of(i_fetch_addr)] ? 1'b1 :
                                lru_m[set_of(i_fetch_addr)];
                end
                if (i_exp_hit !== ((val_m0[set_of(i_fetch_addr)] &&
                                    tag_m0[set_of(i_fetch_addr)] == tag_of(i_fetch_addr)) ||
                                   (val_m1[set_of(i_fetch_addr)] &&
                                    tag_m1[set_of(i_fetch_addr)] == tag_of(i_fetch_addr)))) begin
                    report_text("stimulus table and cache model disagree on hit");
                end
            end
        end
    end

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // active-low reset, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    import icache_pkg::*;

    localparam int ADDR_W   = 32;
    localparam int SET_BITS = 6;
    localparam int NROWS    = 20;

    logic              clk;
    logic              rst;
    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_addr;
    logic              flush;
    logic              exp_hit;
    logic              fetch_ready;
    logic              fetch_valid;
    icache_inst_t      fetch_data;
    logic              fetch_err;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic [2:0]        arprot;
    logic              arready;
    logic              rvalid;
    icache_line_t      rdata;
    axi_resp_t         rresp;
    logic              rready;
    int                errors;
    int                checks;
    int                responses;

    // stimulus table, one row per step
    logic              row_flush [NROWS];
    logic [ADDR_W-1:0] row_addr  [NROWS];
    logic              row_hit   [NROWS];
    int                n_rows;
    int                n_fetches;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    icache_top #(
        .ADDR_W   (ADDR_W),
        .SET_BITS (SET_BITS)
    ) i_icache_top (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .i_flush       (flush),
        .o_fetch_ready (fetch_ready),
        .o_fetch_valid (fetch_valid),
        .o_fetch_data  (fetch_data),
        .o_fetch_err   (fetch_err),
        .o_araddr      (araddr),
        .o_arvalid     (arvalid),
        .o_arprot      (arprot),
        .i_arready     (arready),
        .i_rvalid      (rvalid),
        .i_rdata       (rdata),
        .i_rresp       (rresp),
        .o_rready      (rready)
    );

    tb_axil_mem #(
        .ADDR_W (ADDR_W),
        .SEED   (32'hfb99_35bc)
    ) u_mem (
        .clk       (clk),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .i_rready  (rready),
        .o_arready (arready),
        .o_rvalid  (rvalid),
        .o_rdata   (rdata),
        .o_rresp   (rresp)
    );

    tb_checker #(
        .ADDR_W   (ADDR_W),
        .SET_BITS (SET_BITS)
    ) u_checker (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .i_flush       (flush),
        .i_exp_hit     (exp_hit),
        .i_fetch_ready (fetch_ready),
        .i_fetch_valid (fetch_valid),
        .i_fetch_data  (fetch_data),
        .i_fetch_err   (fetch_err),
        .i_araddr      (araddr),
        .i_arvalid     (arvalid),
        .i_arprot      (arprot),
        .i_arready     (arready),
        .o_errors      (errors),
        .o_checks      (checks),
        .o_responses   (responses)
    );

    task automatic add_row(logic is_flush, logic [ADDR_W-1:0] addr, logic hit);
        row_flush[n_rows] = is_flush;
        row_addr[n_rows]  = addr;
        row_hit[n_rows]   = hit;
        n_rows++;
        if (!is_flush) begin
            n_fetches++;
        end
    endtask

    task automatic fill_table();
        // set 0 holds A=0x1000 and B=0x2000, C=0x4000 competes
        add_row(1'b0, 32'h0000_1000, 1'b0);
        add_row(1'b0, 32'h0000_1004, 1'b1);
        add_row(1'b0, 32'h0000_2000, 1'b0);
        add_row(1'b0, 32'h0000_2004, 1'b1);
        add_row(1'b0, 32'h0000_1000, 1'b1);
        add_row(1'b0, 32'h0000_4000, 1'b0);
        add_row(1'b0, 32'h0000_1004, 1'b1);
        add_row(1'b0, 32'h0000_2000, 1'b0);
        add_row(1'b0, 32'h0000_4000, 1'b0);
        add_row(1'b0, 32'h0000_2004, 1'b1);
        add_row(1'b0, 32'h0000_1040, 1'b0);
        add_row(1'b0, 32'h0000_1044, 1'b1);
        // B and 0x1040 were resident before the flush
        add_row(1'b1, 32'h0000_0000, 1'b0);
        add_row(1'b0, 32'h0000_2000, 1'b0);
        add_row(1'b0, 32'h0000_1044, 1'b0);
        // error region, never allocated
        add_row(1'b0, 32'h0000_3010, 1'b0);
        add_row(1'b0, 32'h0000_3014, 1'b0);
        add_row(1'b0, 32'h0000_2004, 1'b1);
        add_row(1'b0, 32'h0000_05a8, 1'b0);
        add_row(1'b0, 32'h0000_05ac, 1'b1);
    endtask

    // watchdog, 20 cycles per row plus margin
    initial begin
        #(NROWS * 20 * 20 + 2000);
        $display("timeout: the cache stopped answering before all rows were applied");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int local_errors;
        local_errors = 0;
        n_rows       = 0;
        n_fetches    = 0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        flush        = 1'b0;
        exp_hit      = 1'b0;
        fill_table();
        @(posedge rst);
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            while (!fetch_ready) @(negedge clk);
            exp_hit = row_hit[r];
            if (row_flush[r]) begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end else begin
                fetch_req  = 1'b1;
                fetch_addr = row_addr[r];
                @(negedge clk);
                fetch_req  = 1'b0;
            end
        end
        while (!fetch_ready) @(negedge clk);
        repeat (4) @(negedge clk);
        if (responses != n_fetches) begin
            $display("error: %0d responses seen for %0d fetches", responses, n_fetches);
            local_errors++;
        end
        $display("errors: %0d  checks: %0d  responses: %0d",
                 errors + local_errors, checks, responses);
        if (errors + local_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
